// ==== src/sb_consts.svh ====
`ifndef SB_CONSTS_SVH
`define SB_CONSTS_SVH

// instruction window entries
`define SB_WINDOW_DEPTH 8

// window pointer width, one extra bit for wrap
`define SB_PTR_W 4

// integer ALU units
`define SB_FU_NUM 2

// architectural registers
`define SB_NREGS 32

// datapath width
`define SB_XLEN 32

`endif

// ==== src/isa_pkg.sv ====
`include "sb_consts.svh"

package isa_pkg;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        // rd = zero-extended imm
        OP_LI  = 3'd5
    } alu_op_t;

    typedef logic [$clog2(`SB_NREGS)-1:0] reg_idx_t;

    typedef struct packed {
        alu_op_t     op;
        reg_idx_t    rd;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
        logic        fu;
    } inst_t;

endpackage

// ==== src/sb_pkg.sv ====
`include "sb_consts.svh"

package sb_pkg;
    import isa_pkg::*;

    typedef logic [`SB_PTR_W-1:0] win_tag_t;

    // producer of a register value, units 0 and 1 or none
    typedef logic [1:0] fu_tag_t;
    localparam fu_tag_t FU_NONE = 2'd3;

    typedef struct packed {
        logic     valid;
        win_tag_t tag;
        inst_t    inst;
    } disp_t;

    typedef struct packed {
        logic                valid;
        win_tag_t            tag;
        logic [`SB_XLEN-1:0] data;
    } result_t;

    typedef struct packed {
        logic                valid;
        reg_idx_t            rd;
        logic                fu;
        logic [`SB_XLEN-1:0] data;
    } retire_t;

    typedef struct packed {
        logic                valid;
        win_tag_t            seq;
        reg_idx_t            rd;
        logic [`SB_XLEN-1:0] data;
    } commit_t;

endpackage

// ==== src/regfile.sv ====
`timescale 1ns/100ps
`include "sb_consts.svh"

module regfile (
    input  logic                         clk,
    input  logic [$clog2(`SB_NREGS)-1:0] raddr [4],
    output logic [`SB_XLEN-1:0]          rdata [4],
    input  logic                         we,
    input  logic [$clog2(`SB_NREGS)-1:0] waddr,
    input  logic [`SB_XLEN-1:0]          wdata
);

    logic [`SB_XLEN-1:0] mem [`SB_NREGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            mem[waddr] <= wdata;
        end
    end

    // r0 is hardwired, its storage is never written
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata[i] = (raddr[i] == '0) ? '0 : mem[raddr[i]];
        end
    end

endmodule

// ==== src/reg_status.sv ====
`timescale 1ns/100ps

module reg_status
    import isa_pkg::*;
    import sb_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  disp_t   disp,
    input  retire_t retire,
    output logic    rd_pending,
    output fu_tag_t src1_tag,
    output fu_tag_t src2_tag
);

    localparam int NREGS = 2 ** $bits(reg_idx_t);

    fu_tag_t stat [NREGS];

    // a producer retiring this cycle has already written the register file
    function automatic fu_tag_t lookup(input reg_idx_t r, input retire_t ret, input fu_tag_t t);
        lookup = (ret.valid && ret.rd == r) ? FU_NONE : t;
    endfunction

    always_comb begin
        src1_tag = lookup(disp.inst.rs, retire, stat[disp.inst.rs]);
        src2_tag = lookup(disp.inst.rt, retire, stat[disp.inst.rt]);
        // li reads no source registers
        if (disp.inst.op == OP_LI) begin
            src1_tag = FU_NONE;
            src2_tag = FU_NONE;
        end
        rd_pending = lookup(disp.inst.rd, retire, stat[disp.inst.rd]) != FU_NONE;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < NREGS; i++) begin
                stat[i] <= FU_NONE;
            end
        end else begin
            if (retire.valid && retire.rd != '0) begin
                stat[retire.rd] <= FU_NONE;
            end
            if (disp.valid && disp.inst.rd != '0) begin
                stat[disp.inst.rd] <= fu_tag_t'(disp.inst.fu);
            end
        end
    end

endmodule

// ==== src/fu_unit.sv ====
`timescale 1ns/100ps
`include "sb_consts.svh"

module fu_unit
    import isa_pkg::*;
    import sb_pkg::*;
#(
    parameter int FU_ID = 0
) (
    input  logic                clk,
    input  logic                resetn,
    input  disp_t               disp,
    input  fu_tag_t             src1_tag,
    input  fu_tag_t             src2_tag,
    input  retire_t             retire,
    output reg_idx_t            raddr1,
    output reg_idx_t            raddr2,
    input  logic [`SB_XLEN-1:0] rdata1,
    input  logic [`SB_XLEN-1:0] rdata2,
    output logic                busy,
    output result_t             result
);

    logic                take;
    logic                own_retire;
    logic                fire;
    logic                issued;
    fu_tag_t             ret_tag;
    alu_op_t             op_q;
    win_tag_t            tag_q;
    fu_tag_t             t1_q;
    fu_tag_t             t2_q;
    reg_idx_t            rs_q;
    reg_idx_t            rt_q;
    logic [15:0]         imm_q;
    logic                res_valid;
    win_tag_t            res_tag;
    logic [`SB_XLEN-1:0] res_data;

    function automatic logic [`SB_XLEN-1:0] alu(
        input alu_op_t             op,
        input logic [`SB_XLEN-1:0] a,
        input logic [`SB_XLEN-1:0] b,
        input logic [15:0]         imm
    );
        case (op)
            OP_ADD:  alu = a + b;
            OP_SUB:  alu = a - b;
            OP_AND:  alu = a & b;
            OP_OR:   alu = a | b;
            OP_XOR:  alu = a ^ b;
            OP_LI:   alu = `SB_XLEN'(imm);
            default: alu = '0;
        endcase
    endfunction

    assign take       = disp.valid && (int'(disp.inst.fu) == FU_ID);
    assign own_retire = retire.valid && (int'(retire.fu) == FU_ID);
    assign ret_tag    = fu_tag_t'(retire.fu);
    // operands are final once no producer is outstanding
    assign fire       = busy && !issued && t1_q == FU_NONE && t2_q == FU_NONE;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy      <= 1'b0;
            issued    <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= fire;
            if (take) begin
                busy   <= 1'b1;
                issued <= 1'b0;
            end else if (own_retire) begin
                busy <= 1'b0;
            end
            if (fire) begin
                issued <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q  <= disp.inst.op;
            tag_q <= disp.tag;
            rs_q  <= disp.inst.rs;
            rt_q  <= disp.inst.rt;
            imm_q <= disp.inst.imm;
        end
        if (take) begin
            t1_q <= src1_tag;
        end else if (retire.valid && t1_q == ret_tag) begin
            t1_q <= FU_NONE;
        end
        if (take) begin
            t2_q <= src2_tag;
        end else if (retire.valid && t2_q == ret_tag) begin
            t2_q <= FU_NONE;
        end
        if (fire) begin
            res_tag  <= tag_q;
            res_data <= alu(op_q, rdata1, rdata2, imm_q);
        end
    end

    assign raddr1 = rs_q;
    assign raddr2 = rt_q;
    assign result = '{valid: res_valid, tag: res_tag, data: res_data};

endmodule

// ==== src/inst_window.sv ====
`timescale 1ns/100ps
`include "sb_consts.svh"

module inst_window
    import isa_pkg::*;
    import sb_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  in_valid,
    input  inst_t                 in_inst,
    output logic                  stall,
    input  logic [`SB_FU_NUM-1:0] fu_busy,
    input  logic                  rd_pending,
    input  result_t               results [`SB_FU_NUM],
    output disp_t                 disp,
    output retire_t               retire,
    output commit_t               commit
);

    localparam int IDX_W = `SB_PTR_W - 1;

    win_tag_t                    wptr;
    win_tag_t                    dptr;
    win_tag_t                    rptr;
    win_tag_t                    count;
    logic [IDX_W-1:0]            w_idx;
    logic [IDX_W-1:0]            d_idx;
    logic [IDX_W-1:0]            r_idx;
    logic [`SB_WINDOW_DEPTH-1:0] valid;
    logic [`SB_WINDOW_DEPTH-1:0] dispatched;
    logic [`SB_WINDOW_DEPTH-1:0] done;
    inst_t                       inst_q [`SB_WINDOW_DEPTH];
    logic [`SB_XLEN-1:0]         data_q [`SB_WINDOW_DEPTH];
    inst_t                       d_inst;
    inst_t                       r_inst;
    logic                        accept;
    logic                        head_done;

    assign w_idx  = wptr[IDX_W-1:0];
    assign d_idx  = dptr[IDX_W-1:0];
    assign r_idx  = rptr[IDX_W-1:0];
    assign count  = wptr - rptr;
    assign stall  = (count == `SB_PTR_W'(`SB_WINDOW_DEPTH));
    assign accept = in_valid && !stall;

    // oldest undispatched entry goes out once its unit and rd are free
    assign d_inst = inst_q[d_idx];
    assign disp = '{
        valid: valid[d_idx] && !dispatched[d_idx] && !fu_busy[d_inst.fu] && !rd_pending,
        tag:   dptr,
        inst:  d_inst
    };

    assign r_inst    = inst_q[r_idx];
    assign head_done = valid[r_idx] && done[r_idx];
    assign retire = '{valid: head_done, rd: r_inst.rd, fu: r_inst.fu, data: data_q[r_idx]};
    assign commit = '{valid: head_done, seq: rptr, rd: r_inst.rd, data: data_q[r_idx]};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr       <= '0;
            dptr       <= '0;
            rptr       <= '0;
            valid      <= '0;
            dispatched <= '0;
            done       <= '0;
        end else begin
            if (accept) begin
                valid[w_idx]      <= 1'b1;
                dispatched[w_idx] <= 1'b0;
                done[w_idx]       <= 1'b0;
                wptr              <= wptr + 1'b1;
            end
            if (disp.valid) begin
                dispatched[d_idx] <= 1'b1;
                dptr              <= dptr + 1'b1;
            end
            for (int f = 0; f < `SB_FU_NUM; f++) begin
                if (results[f].valid) begin
                    done[results[f].tag[IDX_W-1:0]] <= 1'b1;
                end
            end
            if (head_done) begin
                valid[r_idx] <= 1'b0;
                rptr         <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q[w_idx] <= in_inst;
        end
        for (int f = 0; f < `SB_FU_NUM; f++) begin
            if (results[f].valid) begin
                data_q[results[f].tag[IDX_W-1:0]] <= results[f].data;
            end
        end
    end

endmodule

// ==== src/sb_core.sv ====
`timescale 1ns/100ps
`include "sb_consts.svh"

module sb_core
    import isa_pkg::*;
    import sb_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    in_valid,
    input  inst_t   in_inst,
    output logic    stall,
    output commit_t commit
);

    disp_t                 disp;
    retire_t               retire;
    logic                  rd_pending;
    fu_tag_t               src1_tag;
    fu_tag_t               src2_tag;
    logic [`SB_FU_NUM-1:0] fu_busy;
    result_t               fu_result [`SB_FU_NUM];
    reg_idx_t              rf_raddr [4];
    logic [`SB_XLEN-1:0]   rf_rdata [4];

    inst_window u_window (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .stall      (stall),
        .fu_busy    (fu_busy),
        .rd_pending (rd_pending),
        .results    (fu_result),
        .disp       (disp),
        .retire     (retire),
        .commit     (commit)
    );

    reg_status u_status (
        .clk        (clk),
        .resetn     (resetn),
        .disp       (disp),
        .retire     (retire),
        .rd_pending (rd_pending),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag)
    );

    // ports 0 and 1 serve unit 0, ports 2 and 3 serve unit 1
    fu_unit #(.FU_ID(0)) u_fu0 (
        .clk      (clk),
        .resetn   (resetn),
        .disp     (disp),
        .src1_tag (src1_tag),
        .src2_tag (src2_tag),
        .retire   (retire),
        .raddr1   (rf_raddr[0]),
        .raddr2   (rf_raddr[1]),
        .rdata1   (rf_rdata[0]),
        .rdata2   (rf_rdata[1]),
        .busy     (fu_busy[0]),
        .result   (fu_result[0])
    );

    fu_unit #(.FU_ID(1)) u_fu1 (
        .clk      (clk),
        .resetn   (resetn),
        .disp     (disp),
        .src1_tag (src1_tag),
        .src2_tag (src2_tag),
        .retire   (retire),
        .raddr1   (rf_raddr[2]),
        .raddr2   (rf_raddr[3]),
        .rdata1   (rf_rdata[2]),
        .rdata2   (rf_rdata[3]),
        .busy     (fu_busy[1]),
        .result   (fu_result[1])
    );

    regfile u_regfile (
        .clk   (clk),
        .raddr (rf_raddr),
        .rdata (rf_rdata),
        .we    (retire.valid),
        .waddr (retire.rd),
        .wdata (retire.data)
    );

endmodule

// ==== dv/sb_props.sv ====
`timescale 1ns/100ps
`include "sb_consts.svh"

module sb_props
    import isa_pkg::*;
    import sb_pkg::*;
(
    input logic                        clk,
    input logic                        resetn,
    input logic                        stall,
    input logic                        accept,
    input logic [`SB_PTR_W-2:0]        w_idx,
    input win_tag_t                    count,
    input logic [`SB_WINDOW_DEPTH-1:0] valid,
    input logic [`SB_FU_NUM-1:0]       fu_busy,
    input disp_t                       disp,
    input retire_t                     retire
);

    // assertion failures so far
    int fail_count = 0;

    // entries that went out since they were last written
    logic [`SB_WINDOW_DEPTH-1:0] sent;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sent <= '0;
        end else begin
            if (accept) begin
                sent[w_idx] <= 1'b0;
            end
            if (disp.valid) begin
                sent[disp.tag[`SB_PTR_W-2:0]] <= 1'b1;
            end
        end
    end

    a_no_empty_retire: assert property (@(posedge clk) disable iff (!resetn)
        retire.valid |-> count != '0)
        else begin
            $error("retire from an empty window");
            fail_count++;
        end

    a_stall_full: assert property (@(posedge clk) disable iff (!resetn)
        stall == (&valid))
        else begin
            $error("stall does not match a full window");
            fail_count++;
        end

    a_single_dispatch: assert property (@(posedge clk) disable iff (!resetn)
        disp.valid |-> !sent[disp.tag[`SB_PTR_W-2:0]])
        else begin
            $error("window entry dispatched a second time");
            fail_count++;
        end

    for (genvar f = 0; f < `SB_FU_NUM; f++) begin : g_busy
        a_busy_rise: assert property (@(posedge clk) disable iff (!resetn)
            $rose(fu_busy[f]) |-> $past(disp.valid && disp.inst.fu == f))
            else begin
                $error("unit %0d went busy without a dispatch", f);
                fail_count++;
            end
    end

endmodule

// ==== dv/sb_tb.sv ====
`timescale 1ns/100ps
`include "sb_consts.svh"

module sb_tb
    import isa_pkg::*;
    import sb_pkg::*;
();

    localparam int MAX_TESTS = 64;
    // the last lines of the file are sent with no idle cycles between them
    localparam int BURST_LEN = 12;

    logic    clk;
    logic    resetn;
    logic    in_valid;
    inst_t   in_inst;
    logic    stall;
    commit_t commit;

    inst_t       tests [MAX_TESTS];
    logic [31:0] exp_data [MAX_TESTS];
    int          num_tests;
    int          errors;
    int          accepted;
    int          commits;
    int          seed;
    int          gap;
    int          occ;
    logic        saw_stall;

    sb_core DUT (
        .clk      (clk),
        .resetn   (resetn),
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .stall    (stall),
        .commit   (commit)
    );

    bind inst_window sb_props u_props (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (stall),
        .accept  (accept),
        .w_idx   (w_idx),
        .count   (count),
        .valid   (valid),
        .fu_busy (fu_busy),
        .disp    (disp),
        .retire  (retire)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        int          op;
        int          rd;
        int          rs;
        int          rt;
        int          imm;
        int          fu;
        logic [31:0] data;
        string       line;
        fd = $fopen("dv/sb_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/sb_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %h %d %h", op, rd, rs, rt, imm, fu, data);
                if (n == 7) begin
                    tests[num_tests] = '{op: alu_op_t'(op), rd: reg_idx_t'(rd),
                                         rs: reg_idx_t'(rs), rt: reg_idx_t'(rt),
                                         imm: imm[15:0], fu: fu[0]};
                    exp_data[num_tests] = data;
                    num_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        seed      = 9472;
        errors    = 0;
        accepted  = 0;
        commits   = 0;
        num_tests = 0;
        saw_stall = 1'b0;
        resetn    = 1'b0;
        in_valid  = 1'b0;
        in_inst   = '0;
        load_tests();
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        // idle stretch, the monitor checks stall and commit stay low
        repeat (5) @(posedge clk);
        for (int i = 0; i < num_tests; i++) begin
            gap = (i < num_tests - BURST_LEN) ? ($random(seed) & 3) : 0;
            if (gap > 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            in_valid <= 1'b1;
            in_inst  <= tests[i];
            @(negedge clk);
            while (stall) begin
                @(negedge clk);
            end
            @(posedge clk);
            accepted++;
        end
        in_valid <= 1'b0;
        wait (commits >= num_tests);
        repeat (5) @(posedge clk);
        check_equal("stall seen during burst", saw_stall, 1'b1);
        check_equal("final commit count", commits, num_tests);
        errors += DUT.u_window.u_props.fail_count;
        $display("errors: %0d  commits: %0d of %0d", errors, commits, num_tests);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // outputs are sampled half a cycle after the edge
    always @(negedge clk) begin
        if (resetn) begin
            occ = accepted - commits;
            if (stall) begin
                saw_stall = 1'b1;
            end
            check_equal("in-flight count within depth", occ <= `SB_WINDOW_DEPTH, 1'b1);
            check_equal("stall", stall, occ == `SB_WINDOW_DEPTH);
            if (occ == 0) begin
                check_equal("commit from empty window", commit.valid, 1'b0);
            end
            if (commit.valid) begin
                if (commits >= num_tests) begin
                    $display("commit at %0t after the last test line was retired", $time);
                    errors++;
                end else begin
                    check_equal("commit rd", commit.rd, tests[commits].rd);
                    check_equal("commit data", commit.data, exp_data[commits]);
                    check_equal("commit seq", commit.seq, win_tag_t'(commits));
                end
                commits++;
            end
        end
    end

    initial begin
        #1;
        repeat (num_tests * 40 + 100) @(posedge clk);
        $display("timeout: %0d of %0d instructions committed, the core seems hung",
                 commits, num_tests);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+src
src/isa_pkg.sv
src/sb_pkg.sv
src/regfile.sv
src/reg_status.sv
src/fu_unit.sv
src/inst_window.sv
src/sb_core.sv
dv/sb_props.sv
dv/sb_tb.sv

// ==== dv/sb_tests.txt ====
# op(0 add,1 sub,2 and,3 or,4 xor,5 li) rd rs rt imm(hex) fu expected(hex)
# expected is the commit data in program order, r0 always reads zero
5 1 0 0 1234 0 00001234
5 2 0 0 00ff 1 000000ff
5 3 0 0 f0f0 0 0000f0f0
0 4 1 2 0000 1 00001333
1 5 4 3 0000 0 ffff2243
4 4 4 5 0000 1 ffff3170
5 0 0 0 beef 0 0000beef
3 6 0 2 0000 1 000000ff
2 7 4 3 0000 0 00003070
0 0 1 1 0000 1 00002468
0 8 0 7 0000 0 00003070
5 4 0 0 0005 1 00000005
0 4 4 4 0000 0 0000000a
0 4 4 4 0000 1 00000014
1 9 4 8 0000 0 ffffcfa4
4 10 9 6 0000 1 ffffcf5b
3 11 10 7 0000 0 ffffff7b
2 12 11 1 0000 1 00001230
5 13 0 0 ffff 0 0000ffff
1 14 12 13 0000 1 ffff1231
